/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module rv_core_tb -o rv_core_sim &&
./obj_dir/rv_core_sim | grep -x "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strb_t;

  localparam word_t PC_INIT = 32'h0000_0000;

  // Single-beat memory port
  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } fetch_out_t;

  typedef struct packed {
    word_t                 pc;
    word_t                 op1;
    word_t                 op2;
    word_t                 imm;
    reg_addr_t             rd;
    logic                  rwen;
    rv_isa_pkg::alu_op_t   alu_op;
    rv_isa_pkg::branch_t   branch;
    logic                  mem_read;
    logic                  mem_write;
    word_t                 store_data;
    logic                  halt;
  } exec_ctrl_t;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

/* source/decode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  core_pkg::fetch_out_t fetch_i,
  output core_pkg::reg_addr_t  rs1_o,
  output core_pkg::reg_addr_t  rs2_o,
  input  core_pkg::word_t      rdata1_i,
  input  core_pkg::word_t      rdata2_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output core_pkg::exec_ctrl_t ctrl_o
);
  import core_pkg::*;
  import rv_isa_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  funct7_t    funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  exec_ctrl_t ctrl_d;
  exec_ctrl_t ctrl_q;
  logic       valid_q;

  assign opcode = fetch_i.inst[6:0];
  assign funct3 = fetch_i.inst[14:12];
  assign funct7 = fetch_i.inst[31:25];
  assign rs1_o  = fetch_i.inst[19:15];
  assign rs2_o  = fetch_i.inst[24:20];

  assign imm_i = {{20{fetch_i.inst[31]}}, fetch_i.inst[31:20]};
  assign imm_s = {{20{fetch_i.inst[31]}}, fetch_i.inst[31:25], fetch_i.inst[11:7]};
  assign imm_b = {{19{fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[7],
                  fetch_i.inst[30:25], fetch_i.inst[11:8], 1'b0};
  assign imm_j = {{11{fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[19:12],
                  fetch_i.inst[20], fetch_i.inst[30:21], 1'b0};
  assign imm_u = {fetch_i.inst[31:12], 12'b0};

  always_comb begin
    ctrl_d            = '0;
    ctrl_d.pc         = fetch_i.pc;
    ctrl_d.op1        = rdata1_i;
    ctrl_d.op2        = rdata2_i;
    ctrl_d.rd         = fetch_i.inst[11:7];
    ctrl_d.store_data = rdata2_i;
    ctrl_d.alu_op     = ALU_ADD;
    ctrl_d.branch     = BR_NONE;
    case (opcode)
      OP_IMM: begin
        // Only ADDI in this group
        ctrl_d.op2  = imm_i;
        ctrl_d.imm  = imm_i;
        ctrl_d.rwen = (funct3 == F3_ADD);
        ctrl_d.halt = (funct3 != F3_ADD);
      end
      OP_REG: begin
        if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          ctrl_d.alu_op = ALU_SUB;
          ctrl_d.rwen   = 1'b1;
        end else if (funct7 == F7_BASE) begin
          ctrl_d.rwen = 1'b1;
          case (funct3)
            F3_ADD: ctrl_d.alu_op = ALU_ADD;
            F3_SLT: ctrl_d.alu_op = ALU_SLT;
            F3_XOR: ctrl_d.alu_op = ALU_XOR;
            F3_OR:  ctrl_d.alu_op = ALU_OR;
            F3_AND: ctrl_d.alu_op = ALU_AND;
            default: begin
              ctrl_d.rwen = 1'b0;
              ctrl_d.halt = 1'b1;
            end
          endcase
        end else begin
          ctrl_d.halt = 1'b1;
        end
      end
      OP_LUI: begin
        ctrl_d.alu_op = ALU_PASS_B;
        ctrl_d.op2    = imm_u;
        ctrl_d.imm    = imm_u;
        ctrl_d.rwen   = 1'b1;
      end
      OP_JAL: begin
        ctrl_d.branch = BR_JAL;
        ctrl_d.imm    = imm_j;
        ctrl_d.rwen   = 1'b1;
      end
      OP_BRANCH: begin
        ctrl_d.imm = imm_b;
        case (funct3)
          F3_BEQ:  ctrl_d.branch = BR_EQ;
          F3_BNE:  ctrl_d.branch = BR_NE;
          default: ctrl_d.halt = 1'b1;
        endcase
      end
      OP_LOAD: begin
        ctrl_d.imm      = imm_i;
        ctrl_d.mem_read = (funct3 == F3_LW);
        ctrl_d.rwen     = (funct3 == F3_LW);
        ctrl_d.halt     = (funct3 != F3_LW);
      end
      OP_STORE: begin
        ctrl_d.imm       = imm_s;
        ctrl_d.mem_write = (funct3 == F3_SW);
        ctrl_d.halt      = (funct3 != F3_SW);
      end
      // EBREAK and anything else under SYSTEM stops the core
      OP_SYSTEM: ctrl_d.halt = 1'b1;
      default:   ctrl_d.halt = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ready_o = !valid_q;
  assign valid_o = valid_q;
  assign ctrl_o  = ctrl_q;

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  core_pkg::exec_ctrl_t ctrl_i,
  output logic                 lsu_valid_o,
  input  logic                 lsu_ready_i,
  output core_pkg::lsu_req_t   lsu_req_o,
  input  logic                 lsu_done_i,
  input  core_pkg::word_t      lsu_rdata_i,
  output logic                 rf_we_o,
  output core_pkg::reg_addr_t  rf_waddr_o,
  output core_pkg::word_t      rf_wdata_o,
  output logic                 commit_o,
  output core_pkg::word_t      next_pc_o,
  output logic                 halt_o
);
  import core_pkg::*;
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LSU_REQ,
    LSU_WAIT,
    COMMIT
  } state_t;

  state_t     state_q;
  exec_ctrl_t ctrl_q;
  logic       halt_q;
  word_t      alu_res;
  word_t      pc_plus4;
  word_t      target;
  logic       taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      halt_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i && ready_o) begin
            state_q <= (ctrl_i.mem_read || ctrl_i.mem_write) ? LSU_REQ : COMMIT;
          end
        end
        LSU_REQ: begin
          if (lsu_ready_i) begin
            state_q <= LSU_WAIT;
          end
        end
        LSU_WAIT: begin
          if (lsu_done_i) begin
            state_q <= COMMIT;
          end
        end
        default: begin
          state_q <= IDLE;
          halt_q  <= halt_q | ctrl_q.halt;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      ctrl_q <= ctrl_i;
    end
  end

  always_comb begin
    case (ctrl_q.alu_op)
      ALU_ADD:    alu_res = ctrl_q.op1 + ctrl_q.op2;
      ALU_SUB:    alu_res = ctrl_q.op1 - ctrl_q.op2;
      ALU_AND:    alu_res = ctrl_q.op1 & ctrl_q.op2;
      ALU_OR:     alu_res = ctrl_q.op1 | ctrl_q.op2;
      ALU_XOR:    alu_res = ctrl_q.op1 ^ ctrl_q.op2;
      ALU_SLT:    alu_res = {31'b0, $signed(ctrl_q.op1) < $signed(ctrl_q.op2)};
      ALU_PASS_B: alu_res = ctrl_q.op2;
      default:    alu_res = '0;
    endcase
  end

  // Branch compare works on the raw register operands
  always_comb begin
    case (ctrl_q.branch)
      BR_EQ:   taken = (ctrl_q.op1 == ctrl_q.op2);
      BR_NE:   taken = (ctrl_q.op1 != ctrl_q.op2);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4  = ctrl_q.pc + 32'd4;
  assign target    = ctrl_q.pc + ctrl_q.imm;
  assign next_pc_o = taken ? target : pc_plus4;

  assign ready_o  = (state_q == IDLE) && !halt_q;
  assign commit_o = (state_q == COMMIT);
  assign halt_o   = halt_q | (commit_o & ctrl_q.halt);

  assign lsu_valid_o     = (state_q == LSU_REQ);
  assign lsu_req_o.write = ctrl_q.mem_write;
  assign lsu_req_o.addr  = ctrl_q.op1 + ctrl_q.imm;
  assign lsu_req_o.wdata = ctrl_q.store_data;

  assign rf_we_o    = commit_o & ctrl_q.rwen;
  assign rf_waddr_o = ctrl_q.rd;
  assign rf_wdata_o = ctrl_q.mem_read           ? lsu_rdata_i :
                      (ctrl_q.branch == BR_JAL) ? pc_plus4    : alu_res;

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 commit_i,
  input  core_pkg::word_t      next_pc_i,
  input  logic                 halt_i,
  output core_pkg::mem_req_t   mem_req_o,
  input  logic                 mem_ready_i,
  input  core_pkg::mem_rsp_t   mem_rsp_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output core_pkg::fetch_out_t fetch_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    HAVE
  } state_t;

  state_t state_q;
  word_t  pc_q;
  word_t  inst_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= REQ;
      pc_q    <= PC_INIT;
    end else begin
      case (state_q)
        REQ: begin
          if (mem_ready_i) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (mem_rsp_i.valid) begin
            state_q <= HAVE;
          end
        end
        HAVE: begin
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          // Wait for execute to retire the instruction in flight
          if (commit_i) begin
            pc_q <= next_pc_i;
            if (!halt_i) begin
              state_q <= REQ;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == WAIT && mem_rsp_i.valid) begin
      inst_q <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_o.valid = (state_q == REQ) && !rst;
  assign mem_req_o.write = 1'b0;
  assign mem_req_o.addr  = pc_q;
  assign mem_req_o.wdata = '0;
  assign mem_req_o.wstrb = '0;

  assign valid_o      = (state_q == HAVE);
  assign fetch_o.pc   = pc_q;
  assign fetch_o.inst = inst_q;

endmodule

`default_nettype wire

/* source/load_store_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid_i,
  output logic               ready_o,
  input  core_pkg::lsu_req_t req_i,
  output logic               done_o,
  output core_pkg::word_t    rdata_o,
  output core_pkg::mem_req_t mem_req_o,
  input  logic               mem_ready_i,
  input  core_pkg::mem_rsp_t mem_rsp_i
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_t;

  state_t   state_q;
  lsu_req_t req_q;
  word_t    rdata_q;
  logic     done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= (state_q == WAIT) && mem_rsp_i.valid;
      case (state_q)
        IDLE:    if (valid_i) state_q <= REQ;
        REQ:     if (mem_ready_i) state_q <= WAIT;
        default: if (mem_rsp_i.valid) state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      req_q <= req_i;
    end
    if (state_q == WAIT && mem_rsp_i.valid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  assign ready_o = (state_q == IDLE);
  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  // Word accesses only
  assign mem_req_o.valid = (state_q == REQ);
  assign mem_req_o.write = req_q.write;
  assign mem_req_o.addr  = req_q.addr;
  assign mem_req_o.wdata = req_q.wdata;
  assign mem_req_o.wstrb = req_q.write ? 4'hf : 4'h0;

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::mem_req_t if_req_i,
  output logic               if_ready_o,
  output core_pkg::mem_rsp_t if_rsp_o,
  input  core_pkg::mem_req_t ls_req_i,
  output logic               ls_ready_o,
  output core_pkg::mem_rsp_t ls_rsp_o,
  output core_pkg::mem_req_t mem_req_o,
  input  logic               mem_ready_i,
  input  core_pkg::mem_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    ARB_FREE,
    ARB_IF,
    ARB_LS
  } owner_t;

  owner_t owner_q;
  logic   free;
  logic   sel_ls;

  assign free   = (owner_q == ARB_FREE);
  assign sel_ls = ls_req_i.valid;

  always_comb begin
    mem_req_o       = sel_ls ? ls_req_i : if_req_i;
    mem_req_o.valid = free & (ls_req_i.valid | if_req_i.valid);
  end

  assign ls_ready_o = free & sel_ls & mem_ready_i;
  assign if_ready_o = free & !sel_ls & mem_ready_i;

  // Owner held until its single response returns
  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q <= ARB_FREE;
    end else if (free) begin
      if (mem_req_o.valid && mem_ready_i) begin
        owner_q <= sel_ls ? ARB_LS : ARB_IF;
      end
    end else if (mem_rsp_i.valid) begin
      owner_q <= ARB_FREE;
    end
  end

  assign if_rsp_o.valid = mem_rsp_i.valid & (owner_q == ARB_IF);
  assign if_rsp_o.rdata = mem_rsp_i.rdata;
  assign ls_rsp_o.valid = mem_rsp_i.valid & (owner_q == ARB_LS);
  assign ls_rsp_o.rdata = mem_rsp_i.rdata;

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i,
  input  core_pkg::reg_addr_t raddr1_i,
  input  core_pkg::reg_addr_t raddr2_i,
  output core_pkg::word_t     rdata1_o,
  output core_pkg::word_t     rdata2_o
);
  import core_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic               clk,
  input  logic               rst,
  output core_pkg::mem_req_t mem_req_o,
  input  logic               mem_ready_i,
  input  core_pkg::mem_rsp_t mem_rsp_i,
  output logic               halt_o
);
  import core_pkg::*;

  mem_req_t   if_req;
  mem_rsp_t   if_rsp;
  logic       if_ready;
  mem_req_t   ls_req;
  mem_rsp_t   ls_rsp;
  logic       ls_ready;
  logic       f_valid;
  logic       f_ready;
  fetch_out_t f_out;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rdata1;
  word_t      rdata2;
  logic       d_valid;
  logic       d_ready;
  exec_ctrl_t ctrl;
  logic       lsu_valid;
  logic       lsu_ready;
  lsu_req_t   lsu_req;
  logic       lsu_done;
  word_t      lsu_rdata;
  logic       rf_we;
  reg_addr_t  rf_waddr;
  word_t      rf_wdata;
  logic       commit;
  word_t      next_pc;

  fetch_unit i_fetch_unit (
    .clk(clk), .rst(rst),
    .commit_i(commit), .next_pc_i(next_pc), .halt_i(halt_o),
    .mem_req_o(if_req), .mem_ready_i(if_ready), .mem_rsp_i(if_rsp),
    .valid_o(f_valid), .ready_i(f_ready), .fetch_o(f_out)
  );

  decode_unit i_decode_unit (
    .clk(clk), .rst(rst),
    .valid_i(f_valid), .ready_o(f_ready), .fetch_i(f_out),
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .valid_o(d_valid), .ready_i(d_ready), .ctrl_o(ctrl)
  );

  execute_unit i_execute_unit (
    .clk(clk), .rst(rst),
    .valid_i(d_valid), .ready_o(d_ready), .ctrl_i(ctrl),
    .lsu_valid_o(lsu_valid), .lsu_ready_i(lsu_ready), .lsu_req_o(lsu_req),
    .lsu_done_i(lsu_done), .lsu_rdata_i(lsu_rdata),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .commit_o(commit), .next_pc_o(next_pc), .halt_o(halt_o)
  );

  load_store_unit i_load_store_unit (
    .clk(clk), .rst(rst),
    .valid_i(lsu_valid), .ready_o(lsu_ready), .req_i(lsu_req),
    .done_o(lsu_done), .rdata_o(lsu_rdata),
    .mem_req_o(ls_req), .mem_ready_i(ls_ready), .mem_rsp_i(ls_rsp)
  );

  reg_file i_reg_file (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2)
  );

  mem_arbiter i_mem_arbiter (
    .clk(clk), .rst(rst),
    .if_req_i(if_req), .if_ready_o(if_ready), .if_rsp_o(if_rsp),
    .ls_req_i(ls_req), .ls_ready_o(ls_ready), .ls_rsp_o(ls_rsp),
    .mem_req_o(mem_req_o), .mem_ready_i(mem_ready_i), .mem_rsp_i(mem_rsp_i)
  );

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Major opcodes
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  localparam funct3_t F3_ADD = 3'b000;
  localparam funct3_t F3_SLT = 3'b010;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_OR  = 3'b110;
  localparam funct3_t F3_AND = 3'b111;
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_SW  = 3'b010;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JAL
  } branch_t;

endpackage

`default_nettype wire

/* src.f */
+incdir+tb
source/rv_isa_pkg.sv
source/core_pkg.sv
source/reg_file.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/load_store_unit.sv
source/mem_arbiter.sv
source/rv_core.sv
tb/rv_core_tb.sv

/* tb/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
localparam logic [31:0] BAD_WORD    = 32'hffff_ffff;

// Encoders for the RV32I base formats
function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                      input logic [2:0] f3, input int rd);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                      input int rd, input logic [6:0] op);
  return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                      input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input int imm, input int rd);
  return {imm[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] enc_j(input int imm, input int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
  return enc_i(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

// Results of x1..x10 stored to 0x200 upward
task automatic build_alu_prog();
  prog = {};
  prog.push_back(addi(1, 0, -5));
  prog.push_back(addi(2, 0, 12));
  prog.push_back(enc_u(32'h12345, 3));
  prog.push_back(enc_r(7'h00, 2, 1, 3'b000, 4));
  prog.push_back(enc_r(7'h20, 2, 1, 3'b000, 5));
  prog.push_back(enc_r(7'h00, 2, 1, 3'b111, 6));
  prog.push_back(enc_r(7'h00, 3, 1, 3'b110, 7));
  prog.push_back(enc_r(7'h00, 3, 2, 3'b100, 8));
  prog.push_back(enc_r(7'h00, 2, 1, 3'b010, 9));
  prog.push_back(enc_r(7'h00, 1, 2, 3'b010, 10));
  for (int k = 1; k <= 10; k++) begin
    prog.push_back(enc_s(32'h200 + 4 * (k - 1), k, 0));
  end
  prog.push_back(EBREAK_WORD);
endtask

task automatic build_ls_prog();
  prog = {};
  prog.push_back(addi(1, 0, 100));
  prog.push_back(enc_s(32'h300, 1, 0));
  prog.push_back(enc_i(32'h300, 0, 3'b010, 2, 7'b0000011));
  prog.push_back(addi(3, 0, 23));
  prog.push_back(enc_r(7'h00, 3, 2, 3'b000, 4));
  prog.push_back(enc_s(32'h304, 4, 0));
  // x0 must stay zero
  prog.push_back(addi(0, 0, 77));
  prog.push_back(enc_s(32'h308, 0, 0));
  prog.push_back(EBREAK_WORD);
  exp_addr = {32'h300, 32'h304, 32'h308};
  exp_data = {32'd100, 32'd123, 32'd0};
endtask

task automatic build_cf_prog();
  prog = {};
  prog.push_back(addi(1, 0, 7));
  prog.push_back(addi(2, 0, 7));
  prog.push_back(enc_b(8, 2, 1, 3'b000));
  prog.push_back(enc_s(32'h400, 1, 0));
  prog.push_back(enc_b(8, 2, 1, 3'b001));
  prog.push_back(enc_s(32'h404, 2, 0));
  prog.push_back(addi(2, 0, 9));
  prog.push_back(enc_b(8, 2, 1, 3'b000));
  prog.push_back(enc_b(8, 2, 1, 3'b001));
  prog.push_back(enc_s(32'h408, 1, 0));
  prog.push_back(enc_j(8, 5));
  prog.push_back(enc_s(32'h40c, 1, 0));
  prog.push_back(enc_s(32'h410, 5, 0));
  prog.push_back(EBREAK_WORD);
  // Link of the JAL at 0x28 is 0x28 + 4
  exp_addr = {32'h404, 32'h410};
  exp_data = {32'd7, 32'h28 + 32'd4};
  exp_fetch = {32'h00, 32'h04, 32'h08, 32'h10, 32'h14, 32'h18, 32'h1c, 32'h20,
               32'h28, 32'h30, 32'h34};
endtask

task automatic build_halt_prog(input logic [31:0] stop_word);
  prog = {};
  prog.push_back(addi(1, 0, 1));
  prog.push_back(enc_s(32'h500, 1, 0));
  prog.push_back(stop_word);
  exp_addr = {32'h500};
  exp_data = {32'd1};
endtask

`endif

/* tb/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
  import core_pkg::*;

  // Executed instructions over the normal and back-pressure runs
  localparam int INSTR_TOTAL = 88;
  localparam int CYCLE_LIMIT = INSTR_TOTAL * 20 + 1000;

  logic        clk;
  logic        rst;
  mem_req_t    mem_req;
  logic        mem_ready;
  mem_rsp_t    mem_rsp;
  logic        halt;

  logic [31:0] mem [1024];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_fetch [$];
  logic [31:0] wr_addr [$];
  logic [31:0] wr_data [$];
  logic [31:0] rd_addr [$];
  logic [31:0] rd_word;
  logic [31:0] rnd;
  logic        bp;
  logic        busy;
  int          delay;
  int          accept_count;
  int          cycle_count;
  int          seed;

  `include "tb_program.svh"

  rv_core i_rv_core (
    .clk(clk),
    .rst(rst),
    .mem_req_o(mem_req),
    .mem_ready_i(mem_ready),
    .mem_rsp_i(mem_rsp),
    .halt_o(halt)
  );

  always #4 clk = ~clk;

  // Memory model serving one request at a time
  always @(posedge clk) begin
    mem_rsp.valid <= 1'b0;
    if (rst) begin
      busy      <= 1'b0;
      mem_ready <= !bp;
    end else if (busy) begin
      if (delay <= 1) begin
        mem_rsp.valid <= 1'b1;
        mem_rsp.rdata <= rd_word;
        busy          <= 1'b0;
      end else begin
        delay <= delay - 1;
      end
    end else if (mem_req.valid && mem_ready) begin
      accept_count <= accept_count + 1;
      if (mem_req.write) begin
        check_word("mem_req_o.wstrb", 32'hf, {28'd0, mem_req.wstrb});
        mem[mem_req.addr[11:2]] <= mem_req.wdata;
        wr_addr.push_back(mem_req.addr);
        wr_data.push_back(mem_req.wdata);
      end else begin
        rd_word <= mem[mem_req.addr[11:2]];
        rd_addr.push_back(mem_req.addr);
      end
      busy      <= 1'b1;
      mem_ready <= 1'b0;
      rnd = $random(seed);
      delay <= bp ? int'(rnd[2:1]) + 1 : 1;
    end else begin
      rnd = $random(seed);
      mem_ready <= bp ? rnd[0] : 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("[FAIL] at %0t the run passed %0d cycles without finishing", $time,
               CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic stop_on_error();
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic reset_core();
    @(posedge clk);
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_word("halt_o", 32'd0, {31'd0, halt});
    check_word("mem_req_o.valid", 32'd0, {31'd0, mem_req.valid});
    @(posedge clk);
    // Unused words decode as unsupported
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {i[24:0], 7'h7f};
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
    end
    wr_addr = {};
    wr_data = {};
    rd_addr = {};
    rst <= 1'b0;
    @(negedge clk);
    check_word("halt_o", 32'd0, {31'd0, halt});
    if (!bp) begin
      check_word("mem_req_o.valid", 32'd1, {31'd0, mem_req.valid});
      check_word("mem_req_o.write", 32'd0, {31'd0, mem_req.write});
      check_word("mem_req_o.addr", PC_INIT, mem_req.addr);
    end
  endtask

  task automatic wait_halt();
    while (!halt) begin
      @(negedge clk);
    end
  endtask

  task automatic compare_writes();
    assert (wr_addr.size() == exp_addr.size()) else begin
      $display("[FAIL] at %0t expected %0d writes but saw %0d, writes missing or extra",
               $time, exp_addr.size(), wr_addr.size());
      stop_on_error();
    end
    foreach (exp_addr[i]) begin
      check_word("mem_req_o.addr", exp_addr[i], wr_addr[i]);
      check_word("mem_req_o.wdata", exp_data[i], wr_data[i]);
    end
  endtask

  task automatic run_program();
    reset_core();
    wait_halt();
    check_word("first read mem_req_o.addr", PC_INIT, rd_addr[0]);
    compare_writes();
  endtask

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = 32'd0 - 32'd5;
    b = 32'd12;
    c = {20'h12345, 12'h000};
    build_alu_prog();
    exp_addr = {};
    for (int k = 0; k < 10; k++) begin
      exp_addr.push_back(32'h200 + 4 * k);
    end
    exp_data = {a, b, c, a + b, a - b, a & b, a | c, b ^ c,
                ($signed(a) < $signed(b)) ? 32'd1 : 32'd0,
                ($signed(b) < $signed(a)) ? 32'd1 : 32'd0};
    run_program();
  endtask

  task automatic test_load_store();
    build_ls_prog();
    run_program();
  endtask

  task automatic test_control_flow();
    build_cf_prog();
    run_program();
    assert (rd_addr.size() == exp_fetch.size()) else begin
      $display("[FAIL] at %0t expected %0d fetches but saw %0d", $time, exp_fetch.size(),
               rd_addr.size());
      stop_on_error();
    end
    foreach (exp_fetch[i]) begin
      check_word("fetch mem_req_o.addr", exp_fetch[i], rd_addr[i]);
    end
  endtask

  task automatic test_halt(input logic [31:0] stop_word);
    int count_at_halt;
    build_halt_prog(stop_word);
    run_program();
    count_at_halt = accept_count;
    repeat (20) begin
      @(negedge clk);
      check_word("halt_o", 32'd1, {31'd0, halt});
    end
    assert (accept_count == count_at_halt) else begin
      $display("[FAIL] at %0t a request was accepted after halt", $time);
      stop_on_error();
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    mem_ready    = 1'b0;
    mem_rsp      = '0;
    bp           = 1'b0;
    busy         = 1'b0;
    delay        = 0;
    accept_count = 0;
    cycle_count  = 0;
    seed         = 32'h9e6e_aa78;

    test_alu();
    test_load_store();
    test_control_flow();
    test_halt(EBREAK_WORD);
    test_halt(BAD_WORD);

    // Same programs with random stalls
    bp = 1'b1;
    test_alu();
    test_load_store();
    test_control_flow();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
